/* icache_top.f */
rtl/cache_geom_pkg.sv
rtl/cache_ctrl_pkg.sv
rtl/cache_ifs.sv
rtl/way_ram.sv
rtl/req_decode.sv
rtl/cache_lookup.sv
rtl/data_return.sv
rtl/icache_top.sv
verification/icache_tb.sv

/* rtl/cache_ctrl_pkg.sv */
`default_nettype none

package cache_ctrl_pkg;

    // request opcode on the cpu port
    typedef enum logic {
        OP_FETCH = 1'b0,
        OP_INVAL = 1'b1
    } req_op_t;

    // main controller FSM
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        LOOKUP   = 2'd1,
        MISS_REQ = 2'd2,
        REFILL   = 2'd3
    } ctrl_state_t;

    // where the returned word comes from
    typedef enum logic [1:0] {
        SRC_BANK = 2'd0,
        SRC_FILL = 2'd1,
        SRC_NONE = 2'd2
    } resp_src_t;

endpackage

`default_nettype wire

/* rtl/cache_geom_pkg.sv */
`default_nettype none

package cache_geom_pkg;

    // cache organisation
    localparam int NUM_WAYS       = 2;
    localparam int NUM_SETS       = 256;
    localparam int WORDS_PER_LINE = 4;

    // address split: tag | index | offset
    localparam int TAG_W      = 20;
    localparam int INDEX_W    = 8;
    localparam int OFFSET_W   = 4;
    localparam int WORD_SEL_W = $clog2(WORDS_PER_LINE);

    typedef logic [31:0]           addr_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [INDEX_W-1:0]    index_t;
    typedef logic [WORD_SEL_W-1:0] word_sel_t;
    typedef logic [31:0]           word_t;

    // one tag array entry
    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

endpackage

`default_nettype wire

/* rtl/cache_ifs.sv */
`default_nettype none

// buffered request and ram index from the decode stage
interface lookup_if;
    logic                      accept;
    cache_ctrl_pkg::req_op_t   buf_op;
    cache_geom_pkg::tag_t      buf_tag;
    cache_geom_pkg::index_t    buf_index;
    cache_geom_pkg::word_sel_t buf_word;
    cache_geom_pkg::index_t    ram_index;
    logic                      ready;

    modport decode (output accept, buf_op, buf_tag, buf_index, buf_word, ram_index,
                    input  ready);
    modport lookup (input  accept, buf_op, buf_tag, buf_index, ram_index,
                    output ready);
    modport result (input  buf_word, ram_index);
endinterface

// refill beat control towards the data banks
interface refill_if;
    logic                      fill_way;
    logic                      beat_we;
    cache_geom_pkg::word_sel_t beat_sel;
    logic                      fill_done;

    modport ctrl   (output fill_way, beat_we, beat_sel, fill_done);
    modport result (input  fill_way, beat_we, beat_sel, fill_done);
endinterface

// lookup outcome
interface resp_if;
    logic                      resp_valid;
    cache_ctrl_pkg::resp_src_t resp_src;
    logic                      hit_way;

    modport ctrl   (output resp_valid, resp_src, hit_way);
    modport result (input  resp_valid, resp_src, hit_way);
endinterface

`default_nettype wire

/* rtl/cache_lookup.sv */
`default_nettype none

module cache_lookup (
    input  logic                  clk,
    input  logic                  resetn,
    lookup_if.lookup              lk,
    refill_if.ctrl                fill,
    resp_if.ctrl                  resp,
    output logic                  rd_req,
    output cache_geom_pkg::addr_t rd_addr,
    input  logic                  rd_rdy,
    input  logic                  ret_valid,
    input  logic                  ret_last
);

    cache_ctrl_pkg::ctrl_state_t         state;
    cache_ctrl_pkg::ctrl_state_t         state_nxt;
    cache_geom_pkg::tagv_t               tagv_rdata [cache_geom_pkg::NUM_WAYS];
    cache_geom_pkg::tagv_t               tagv_wdata;
    logic [cache_geom_pkg::NUM_SETS-1:0] valid_bits [cache_geom_pkg::NUM_WAYS];
    logic [cache_geom_pkg::NUM_SETS-1:0] lru_bits;
    logic [cache_geom_pkg::NUM_WAYS-1:0] way_valid;
    logic [cache_geom_pkg::NUM_WAYS-1:0] way_hit;
    logic                                any_hit;
    logic                                hit_way_idx;
    logic                                victim_way;
    logic                                lookup_fetch;
    logic                                lookup_inval;
    logic                                fetch_hit;
    logic                                fill_way_q;
    cache_geom_pkg::word_sel_t           beat_cnt;
    logic                                beat_we;
    logic                                fill_done;

    assign tagv_wdata = '{valid: 1'b1, tag: lk.buf_tag};

    for (genvar w = 0; w < cache_geom_pkg::NUM_WAYS; w++)
    begin : g_tagv
        way_ram #(
            .payload_t (cache_geom_pkg::tagv_t),
            .DEPTH     (cache_geom_pkg::NUM_SETS)
        ) u_tagv (
            .clk   (clk),
            .we    (fill_done && (fill_way_q == 1'(w))),
            .addr  (lk.ram_index),
            .wdata (tagv_wdata),
            .rdata (tagv_rdata[w])
        );

        // register valid bit qualifies whatever the ram holds
        assign way_valid[w] = valid_bits[w][lk.buf_index];
        assign way_hit[w]   = way_valid[w] && tagv_rdata[w].valid
                              && (tagv_rdata[w].tag == lk.buf_tag);
    end

    assign any_hit     = |way_hit;
    assign hit_way_idx = way_hit[1];

    // empty way first, then the lru way
    assign victim_way = !way_valid[0] ? 1'b0 :
                        !way_valid[1] ? 1'b1 : lru_bits[lk.buf_index];

    assign lookup_fetch = (state == cache_ctrl_pkg::LOOKUP)
                          && (lk.buf_op == cache_ctrl_pkg::OP_FETCH);
    assign lookup_inval = (state == cache_ctrl_pkg::LOOKUP)
                          && (lk.buf_op == cache_ctrl_pkg::OP_INVAL);
    assign fetch_hit    = lookup_fetch && any_hit;

    assign beat_we   = (state == cache_ctrl_pkg::REFILL) && ret_valid;
    assign fill_done = beat_we && ret_last;

    always_comb
    begin
        state_nxt = state;
        unique case (state)
            cache_ctrl_pkg::IDLE:
                if (lk.accept)
                    state_nxt = cache_ctrl_pkg::LOOKUP;
            cache_ctrl_pkg::LOOKUP:
                if (lookup_fetch && !any_hit)
                    state_nxt = cache_ctrl_pkg::MISS_REQ;
                else if (lk.accept)
                    state_nxt = cache_ctrl_pkg::LOOKUP;
                else
                    state_nxt = cache_ctrl_pkg::IDLE;
            cache_ctrl_pkg::MISS_REQ:
                if (rd_rdy)
                    state_nxt = cache_ctrl_pkg::REFILL;
            cache_ctrl_pkg::REFILL:
                if (fill_done)
                    state_nxt = cache_ctrl_pkg::IDLE;
            default:
                state_nxt = cache_ctrl_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state      <= cache_ctrl_pkg::IDLE;
            valid_bits <= '{default: '0};
            lru_bits   <= '0;
            fill_way_q <= 1'b0;
            beat_cnt   <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (lookup_fetch && !any_hit)
                fill_way_q <= victim_way;
            // lru bit names the way to evict next
            if (fill_done)
            begin
                valid_bits[fill_way_q][lk.buf_index] <= 1'b1;
                lru_bits[lk.buf_index]               <= ~fill_way_q;
            end
            else if (fetch_hit)
                lru_bits[lk.buf_index] <= ~hit_way_idx;
            else if (lookup_inval && any_hit)
                valid_bits[hit_way_idx][lk.buf_index] <= 1'b0;
            if (fill_done)
                beat_cnt <= '0;
            else if (beat_we)
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

    assign lk.ready = (state == cache_ctrl_pkg::IDLE) || fetch_hit;

    // line aligned burst read
    assign rd_req  = (state == cache_ctrl_pkg::MISS_REQ);
    assign rd_addr = {lk.buf_tag, lk.buf_index, {cache_geom_pkg::OFFSET_W{1'b0}}};

    assign fill.fill_way  = fill_way_q;
    assign fill.beat_we   = beat_we;
    assign fill.beat_sel  = beat_cnt;
    assign fill.fill_done = fill_done;

    assign resp.resp_valid = fetch_hit || lookup_inval || fill_done;
    assign resp.resp_src   = fill_done ? cache_ctrl_pkg::SRC_FILL :
                             fetch_hit ? cache_ctrl_pkg::SRC_BANK : cache_ctrl_pkg::SRC_NONE;
    assign resp.hit_way    = hit_way_idx;

endmodule

`default_nettype wire

/* rtl/data_return.sv */
`default_nettype none

module data_return (
    input  logic                  clk,
    input  logic                  resetn,
    lookup_if.result              lk,
    refill_if.result              fill,
    resp_if.result                resp,
    input  cache_geom_pkg::word_t ret_data,
    output logic                  data_ok,
    output cache_geom_pkg::word_t rdata
);

    cache_geom_pkg::word_t bank_rdata [cache_geom_pkg::NUM_WAYS][cache_geom_pkg::WORDS_PER_LINE];
    cache_geom_pkg::word_t fill_word;
    logic                  fill_ok;

    // one bank per word position in each way
    for (genvar w = 0; w < cache_geom_pkg::NUM_WAYS; w++)
    begin : g_way
        for (genvar b = 0; b < cache_geom_pkg::WORDS_PER_LINE; b++)
        begin : g_bank
            way_ram #(
                .payload_t (cache_geom_pkg::word_t),
                .DEPTH     (cache_geom_pkg::NUM_SETS)
            ) u_bank (
                .clk   (clk),
                .we    (fill.beat_we && (fill.fill_way == 1'(w))
                        && (fill.beat_sel == cache_geom_pkg::word_sel_t'(b))),
                .addr  (lk.ram_index),
                .wdata (ret_data),
                .rdata (bank_rdata[w][b])
            );
        end
    end

    // grab the requested word as its beat goes past
    always_ff @(posedge clk)
    begin
        if (fill.beat_we && (fill.beat_sel == lk.buf_word))
        begin
            fill_word <= ret_data;
        end
    end

    // miss answer goes out the cycle after the last beat
    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            fill_ok <= 1'b0;
        end
        else
        begin
            fill_ok <= fill.fill_done;
        end
    end

    assign data_ok = fill_ok
                     || (resp.resp_valid && (resp.resp_src != cache_ctrl_pkg::SRC_FILL));

    always_comb
    begin
        if (fill_ok)
            rdata = fill_word;
        else if (resp.resp_src == cache_ctrl_pkg::SRC_BANK)
            rdata = bank_rdata[resp.hit_way][lk.buf_word];
        else
            rdata = '0;
    end

endmodule

`default_nettype wire

/* rtl/icache_top.sv */
`default_nettype none

module icache_top (
    input  logic                    clk,
    input  logic                    resetn,

    // cpu request / response
    input  logic                    valid,
    input  cache_ctrl_pkg::req_op_t op,
    input  cache_geom_pkg::addr_t   addr,
    output logic                    addr_ok,
    output logic                    data_ok,
    output cache_geom_pkg::word_t   rdata,

    // burst read bus
    output logic                    rd_req,
    output cache_geom_pkg::addr_t   rd_addr,
    input  logic                    rd_rdy,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    input  cache_geom_pkg::word_t   ret_data
);

    lookup_if lk_bus ();
    refill_if fill_bus ();
    resp_if   resp_bus ();

    assign addr_ok = lk_bus.ready;

    req_decode u_decode (
        .clk    (clk),
        .resetn (resetn),
        .valid  (valid),
        .op     (op),
        .addr   (addr),
        .lk     (lk_bus)
    );

    cache_lookup u_lookup (
        .clk       (clk),
        .resetn    (resetn),
        .lk        (lk_bus),
        .fill      (fill_bus),
        .resp      (resp_bus),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last)
    );

    data_return u_return (
        .clk      (clk),
        .resetn   (resetn),
        .lk       (lk_bus),
        .fill     (fill_bus),
        .resp     (resp_bus),
        .ret_data (ret_data),
        .data_ok  (data_ok),
        .rdata    (rdata)
    );

endmodule

`default_nettype wire

/* rtl/req_decode.sv */
`default_nettype none

module req_decode (
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    valid,
    input  cache_ctrl_pkg::req_op_t op,
    input  cache_geom_pkg::addr_t   addr,
    lookup_if.decode                lk
);

    cache_geom_pkg::tag_t      addr_tag;
    cache_geom_pkg::index_t    addr_index;
    cache_geom_pkg::word_sel_t addr_word;

    // address fields
    assign addr_tag   = addr[31 -: cache_geom_pkg::TAG_W];
    assign addr_index = addr[cache_geom_pkg::OFFSET_W +: cache_geom_pkg::INDEX_W];
    assign addr_word  = addr[cache_geom_pkg::OFFSET_W-1 -: cache_geom_pkg::WORD_SEL_W];

    assign lk.accept = valid && lk.ready;

    // new set goes to the rams as soon as it is accepted,
    // otherwise keep reading the set being resolved
    assign lk.ram_index = lk.accept ? addr_index : lk.buf_index;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            lk.buf_op <= cache_ctrl_pkg::OP_FETCH;
        end
        else if (lk.accept)
        begin
            lk.buf_op <= op;
        end
    end

    // request payload
    always_ff @(posedge clk)
    begin
        if (lk.accept)
        begin
            lk.buf_tag   <= addr_tag;
            lk.buf_index <= addr_index;
            lk.buf_word  <= addr_word;
        end
    end

endmodule

`default_nettype wire

/* rtl/way_ram.sv */
`default_nettype none

// single port ram, registered read
module way_ram #(
    parameter type payload_t = cache_geom_pkg::word_t,
    parameter int  DEPTH     = cache_geom_pkg::NUM_SETS
) (
    input  logic                   clk,
    input  logic                   we,
    input  cache_geom_pkg::index_t addr,
    input  payload_t               wdata,
    output payload_t               rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[addr] <= wdata;
        end
        // old contents come out on a write cycle
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

/* verification/icache_tb.sv */
`default_nettype none

module icache_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam cache_geom_pkg::word_t mem_pattern = 32'h5a3c_96e1;
    // 16 directed requests plus the random stream
    localparam int num_requests   = 16 + 300;
    localparam int timeout_cycles = num_requests * 20 + 200;
    localparam int req_limit      = 40;

    logic                    clk = 1'b0;
    logic                    resetn;
    logic                    valid;
    cache_ctrl_pkg::req_op_t op;
    cache_geom_pkg::addr_t   addr;
    logic                    addr_ok;
    logic                    data_ok;
    cache_geom_pkg::word_t   rdata;
    logic                    rd_req;
    cache_geom_pkg::addr_t   rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    cache_geom_pkg::word_t   ret_data;

    integer seed;
    int     cycle_cnt = 0;
    int     test_errors = 0;
    int     pass_count = 0;
    int     fail_count = 0;

    // what the memory side saw during the current request
    logic                  refill_seen;
    cache_geom_pkg::addr_t last_rd_addr;

    // reference model state
    cache_geom_pkg::tag_t m_tag [cache_geom_pkg::NUM_SETS][cache_geom_pkg::NUM_WAYS];
    logic                 m_valid [cache_geom_pkg::NUM_SETS][cache_geom_pkg::NUM_WAYS];
    logic                 m_lru [cache_geom_pkg::NUM_SETS];

    icache_top DUT (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .addr      (addr),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data)
    );

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles)
        begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("tests failed");
            $finish;
        end
    end

    task automatic note_error(input string msg);
        $display("%s", msg);
        test_errors++;
    endtask

    task automatic compare_word(input string name, input cache_geom_pkg::word_t expected,
                                input cache_geom_pkg::word_t actual);
        if (expected !== actual)
            note_error($sformatf("[FAIL] %s: rdata expected %h, actual %h",
                                 name, expected, actual));
    endtask

    task automatic compare_addr(input string name, input cache_geom_pkg::addr_t expected,
                                input cache_geom_pkg::addr_t actual);
        if (expected !== actual)
            note_error($sformatf("[FAIL] %s: rd_addr expected %h, actual %h",
                                 name, expected, actual));
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual)
            note_error($sformatf("[FAIL] %s: flag expected %b, actual %b",
                                 name, expected, actual));
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0)
        begin
            pass_count++;
            $display("[PASS] %s", name);
        end
        else
        begin
            fail_count++;
            $display("test %s finished with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    function automatic cache_geom_pkg::addr_t make_addr(input cache_geom_pkg::tag_t t,
                                                        input cache_geom_pkg::index_t idx,
                                                        input cache_geom_pkg::word_sel_t w);
        return {t, idx, w, 2'b00};
    endfunction

    // predicts the outcome and updates the model
    task automatic model_access(input cache_ctrl_pkg::req_op_t req_op,
                                input cache_geom_pkg::addr_t a, output logic miss,
                                output cache_geom_pkg::word_t word,
                                output cache_geom_pkg::addr_t line);
        cache_geom_pkg::tag_t   t;
        cache_geom_pkg::index_t idx;
        int                     way;
        int                     victim;
        int                     w;
        t    = a[31:12];
        idx  = a[11:4];
        way  = -1;
        line = {a[31:4], 4'b0000};
        miss = 1'b0;
        word = '0;
        for (w = 0; w < cache_geom_pkg::NUM_WAYS; w++)
            if (m_valid[idx][w] && m_tag[idx][w] == t)
                way = w;
        if (req_op == cache_ctrl_pkg::OP_INVAL)
        begin
            if (way >= 0)
                m_valid[idx][way] = 1'b0;
        end
        else
        begin
            word = {a[31:2], 2'b00} ^ mem_pattern;
            // lru bit points at the way to evict next
            if (way >= 0)
                m_lru[idx] = (way == 0);
            else
            begin
                miss = 1'b1;
                if (!m_valid[idx][0])
                    victim = 0;
                else if (!m_valid[idx][1])
                    victim = 1;
                else
                    victim = m_lru[idx];
                m_tag[idx][victim]   = t;
                m_valid[idx][victim] = 1'b1;
                m_lru[idx]           = (victim == 0);
            end
        end
    endtask

    // memory side of one burst, entered at a falling edge with rd_req high
    task automatic serve_refill(input string name);
        int delay;
        int gap;
        int beat;
        last_rd_addr = rd_addr;
        refill_seen  = 1'b1;
        delay = $unsigned($random(seed)) % 4;
        repeat (delay)
        begin
            @(negedge clk);
            compare_flag({name, " held rd_req"}, 1'b1, rd_req);
            compare_addr({name, " held rd_addr"}, last_rd_addr, rd_addr);
        end
        rd_rdy = 1'b1;
        @(negedge clk);
        rd_rdy = 1'b0;
        for (beat = 0; beat < cache_geom_pkg::WORDS_PER_LINE; beat++)
        begin
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(negedge clk);
            ret_valid = 1'b1;
            ret_last  = (beat == cache_geom_pkg::WORDS_PER_LINE - 1);
            ret_data  = (last_rd_addr + cache_geom_pkg::addr_t'(beat * 4)) ^ mem_pattern;
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    // one request from issue to data_ok, starts and ends on a falling edge
    task automatic do_request(input string name, input cache_ctrl_pkg::req_op_t req_op,
                              input cache_geom_pkg::addr_t a);
        logic                  exp_miss;
        cache_geom_pkg::word_t exp_word;
        cache_geom_pkg::addr_t exp_line;
        int                    waited;
        int                    lat;
        model_access(req_op, a, exp_miss, exp_word, exp_line);
        refill_seen = 1'b0;
        valid = 1'b1;
        op    = req_op;
        addr  = a;
        waited = 0;
        while (!addr_ok && waited < req_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (!addr_ok)
        begin
            valid = 1'b0;
            note_error($sformatf("%s: request was never accepted", name));
        end
        else
        begin
            @(negedge clk);
            valid = 1'b0;
            lat = 1;
            while (!data_ok && lat < req_limit)
            begin
                if (rd_req && !refill_seen)
                begin
                    serve_refill(name);
                    // answer is due the cycle after the last beat
                    if (!data_ok)
                        note_error($sformatf("%s: data_ok did not follow the last beat",
                                             name));
                end
                else
                begin
                    @(negedge clk);
                    lat++;
                end
            end
            if (!data_ok)
                note_error($sformatf("%s: data_ok never came", name));
            else
            begin
                if (refill_seen && !exp_miss)
                    note_error($sformatf("%s: unexpected rd_req on a hit", name));
                else
                    compare_flag({name, " refill"}, exp_miss, refill_seen);
                if (exp_miss && refill_seen)
                    compare_addr(name, exp_line, last_rd_addr);
                if (!exp_miss && !refill_seen && lat != 1)
                    note_error($sformatf("%s: data_ok came %0d cycles after acceptance",
                                         name, lat));
                compare_word(name, exp_word, rdata);
            end
        end
    endtask

    // two fetch hits accepted on consecutive cycles
    task automatic hit_pair(input string name, input cache_geom_pkg::addr_t a0,
                            input cache_geom_pkg::addr_t a1);
        logic                  miss0;
        logic                  miss1;
        cache_geom_pkg::word_t exp0;
        cache_geom_pkg::word_t exp1;
        cache_geom_pkg::addr_t line;
        int                    waited;
        model_access(cache_ctrl_pkg::OP_FETCH, a0, miss0, exp0, line);
        model_access(cache_ctrl_pkg::OP_FETCH, a1, miss1, exp1, line);
        valid  = 1'b1;
        op     = cache_ctrl_pkg::OP_FETCH;
        addr   = a0;
        waited = 0;
        while (!addr_ok && waited < req_limit)
        begin
            @(negedge clk);
            waited++;
        end
        @(negedge clk);
        // a hit in lookup answers at once and takes the next request
        compare_flag({name, " second addr_ok"}, !miss0, addr_ok);
        compare_flag({name, " first data_ok"}, !miss0, data_ok);
        compare_word({name, " first"}, exp0, rdata);
        addr = a1;
        @(negedge clk);
        valid = 1'b0;
        compare_flag({name, " second data_ok"}, !miss1, data_ok);
        compare_word({name, " second"}, exp1, rdata);
        compare_flag({name, " rd_req"}, 1'b0, rd_req);
    endtask

    initial
    begin
        cache_ctrl_pkg::req_op_t   r_op;
        cache_geom_pkg::tag_t      r_tag;
        cache_geom_pkg::index_t    r_index;
        cache_geom_pkg::word_sel_t r_word;
        seed      = 32'h3db3_c92d;
        resetn    = 1'b0;
        valid     = 1'b0;
        op        = cache_ctrl_pkg::OP_FETCH;
        addr      = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        for (int s = 0; s < cache_geom_pkg::NUM_SETS; s++)
        begin
            m_valid[s][0] = 1'b0;
            m_valid[s][1] = 1'b0;
            m_lru[s]      = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        compare_flag("reset addr_ok", 1'b1, addr_ok);
        compare_flag("reset rd_req", 1'b0, rd_req);
        compare_flag("reset data_ok", 1'b0, data_ok);
        finish_test("reset");

        do_request("cold_miss", cache_ctrl_pkg::OP_FETCH, make_addr(20'h12345, 8'h10, 2'd2));
        finish_test("cold_miss");

        do_request("hits word0", cache_ctrl_pkg::OP_FETCH, make_addr(20'h12345, 8'h10, 2'd0));
        hit_pair("hits pair", make_addr(20'h12345, 8'h10, 2'd1),
                 make_addr(20'h12345, 8'h10, 2'd3));
        finish_test("hits");

        // A, B, A, C in one set, then C has pushed out B
        do_request("repl A", cache_ctrl_pkg::OP_FETCH, make_addr(20'haaaaa, 8'h20, 2'd0));
        do_request("repl B", cache_ctrl_pkg::OP_FETCH, make_addr(20'hbbbbb, 8'h20, 2'd1));
        do_request("repl A again", cache_ctrl_pkg::OP_FETCH, make_addr(20'haaaaa, 8'h20, 2'd2));
        do_request("repl C", cache_ctrl_pkg::OP_FETCH, make_addr(20'hccccc, 8'h20, 2'd3));
        do_request("repl A kept", cache_ctrl_pkg::OP_FETCH, make_addr(20'haaaaa, 8'h20, 2'd1));
        do_request("repl B gone", cache_ctrl_pkg::OP_FETCH, make_addr(20'hbbbbb, 8'h20, 2'd0));
        finish_test("replacement");

        do_request("inval X fill", cache_ctrl_pkg::OP_FETCH, make_addr(20'h11111, 8'h30, 2'd0));
        do_request("inval Y fill", cache_ctrl_pkg::OP_FETCH, make_addr(20'h22222, 8'h30, 2'd1));
        do_request("inval X", cache_ctrl_pkg::OP_INVAL, make_addr(20'h11111, 8'h30, 2'd0));
        do_request("inval X refetch", cache_ctrl_pkg::OP_FETCH,
                   make_addr(20'h11111, 8'h30, 2'd2));
        do_request("inval absent", cache_ctrl_pkg::OP_INVAL, make_addr(20'h33333, 8'h30, 2'd0));
        do_request("inval Y kept", cache_ctrl_pkg::OP_FETCH, make_addr(20'h22222, 8'h30, 2'd3));
        finish_test("invalidate");

        // three tags over four sets keeps the two ways busy
        for (int n = 0; n < 300; n++)
        begin
            r_op    = (($random(seed) & 3) == 0) ? cache_ctrl_pkg::OP_INVAL
                                                 : cache_ctrl_pkg::OP_FETCH;
            r_tag   = cache_geom_pkg::tag_t'(20'h40000 + $unsigned($random(seed)) % 3);
            r_index = cache_geom_pkg::index_t'(8'h80 + $unsigned($random(seed)) % 4);
            r_word  = cache_geom_pkg::word_sel_t'($random(seed));
            do_request($sformatf("random #%0d", n), r_op, make_addr(r_tag, r_index, r_word));
        end
        finish_test("random_stream");

        $display("summary: %0d passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire
